// File: rtl/multicore_pkg.sv
package multicore_pkg;

	// ########################################################################
	// Array size and timing
	// ########################################################################

	localparam int num_cores = 4;
	localparam int samples_per_core = 4;

	// Keep at least samples_per_core + 2 so two cores never request together
	localparam int dwell_cycles = 8;

	localparam int data_width = 32;
	localparam int dwell_w = $clog2(dwell_cycles + 1);
	localparam int cnt_w = $clog2(samples_per_core);

	// ########################################################################
	// Types
	// ########################################################################

	typedef logic [1:0] core_idx_t;
	typedef logic [1:0] en_t;
	typedef logic signed [data_width-1:0] sample_t;

	localparam en_t en_idle = 2'd0;
	localparam en_t en_valid = 2'd1;   // Sum present for one cycle
	localparam en_t en_done = 2'd2;

	typedef struct packed {
		sample_t data;
		en_t en;
	} core_out_t;

	typedef core_out_t [num_cores-1:0] core_out_vec_t;

	// Request code per core, 1 while requesting
	typedef logic [num_cores-1:0][1:0] req_vec_t;

endpackage

// File: rtl/dwell_timer.sv
module dwell_timer (
	input logic clk,
	input logic reset,
	input logic start,
	output logic expire
);

	import multicore_pkg::*;

	logic [dwell_w-1:0] count;   // Zero when idle

	// ########################################################################
	// Down-counter
	// ########################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (start) begin
			count <= dwell_w'(dwell_cycles);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Last cycle of the count, so the release lands on the dwell edge
	assign expire = (count == dwell_w'(1));

	// ########################################################################
	// Checks
	// ########################################################################

	// A new dwell may only begin once the previous one has run out
	a_no_restart: assert property (
		@(posedge clk) disable iff (reset)
		start |-> (count == '0 || expire)
	);

endmodule

// File: rtl/release_fsm.sv
module release_fsm (
	input logic clk,
	input logic reset,
	input logic expire,
	output logic start,
	output logic [multicore_pkg::num_cores-1:0] core_reset
);

	import multicore_pkg::*;

	typedef enum logic [1:0] {
		st_hold,
		st_releasing,
		st_finished
	} state_t;

	state_t state;
	core_idx_t next_idx;   // Next core to come out of reset
	logic last_core;

	assign last_core = (next_idx == core_idx_t'(num_cores - 1));

	// ########################################################################
	// Release sequencer
	// ########################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_hold;
			next_idx <= '0;
			core_reset <= '1;
		end else begin
			case (state)
				st_hold: begin
					core_reset[0] <= 1'b0;
					next_idx <= core_idx_t'(1);
					state <= st_releasing;
				end
				st_releasing: begin
					if (expire) begin
						core_reset[next_idx] <= 1'b0;
						if (last_core)
							state <= st_finished;
						else
							next_idx <= next_idx + 1'b1;
					end
				end
				default: begin
					state <= st_finished;   // All cores running
				end
			endcase
		end
	end

	// Timer runs for every release except the last one
	always_comb begin
		start = 1'b0;
		if (state == st_hold)
			start = 1'b1;
		else if (state == st_releasing && expire && !last_core)
			start = 1'b1;
	end

	// ########################################################################
	// Checks
	// ########################################################################

	// A released core stays released
	a_reset_falls_only: assert property (
		@(posedge clk) disable iff (reset)
		(core_reset & ~$past(core_reset)) == '0
	);

	a_start_pulse: assert property (
		@(posedge clk) disable iff (reset)
		start |=> !start
	);

endmodule

// File: rtl/sample_core.sv
module sample_core (
	input logic clk,
	input logic core_reset,
	input multicore_pkg::sample_t io_in,
	output logic [1:0] req,
	output multicore_pkg::core_out_t core_out
);

	import multicore_pkg::*;

	typedef enum logic [1:0] {
		st_entry,
		st_collect,
		st_report,
		st_done
	} state_t;

	state_t state;
	logic [cnt_w-1:0] cnt;
	sample_t sum;
	logic last_sample;

	assign last_sample = (cnt == cnt_w'(samples_per_core - 1));

	// ########################################################################
	// Control
	// ########################################################################

	always_ff @(posedge clk) begin
		if (core_reset) begin
			state <= st_entry;
		end else begin
			case (state)
				st_entry: state <= st_collect;
				st_collect: begin
					if (last_sample)
						state <= st_report;
				end
				st_report: state <= st_done;
				default: state <= st_done;   // Parked
			endcase
		end
	end

	// ########################################################################
	// Datapath
	// ########################################################################

	// Counter and sum are cleared while the core sits in its entry state
	always_ff @(posedge clk) begin
		case (state)
			st_entry: begin
				cnt <= '0;
				sum <= '0;
			end
			st_collect: begin
				cnt <= cnt + 1'b1;
				sum <= sum + io_in;   // Wraps on overflow
			end
			default: begin
				cnt <= cnt;
				sum <= sum;
			end
		endcase
	end

	assign req = (state == st_collect) ? 2'd1 : 2'd0;

	always_comb begin
		core_out.data = sum;
		case (state)
			st_report: core_out.en = en_valid;
			st_done: core_out.en = en_done;
			default: core_out.en = en_idle;
		endcase
	end

	// ########################################################################
	// Checks
	// ########################################################################

	// One valid cycle, then done for good
	a_valid_once: assert property (
		@(posedge clk) disable iff (core_reset)
		core_out.en == en_valid |=> core_out.en == en_done
	);

	// The request window is exactly samples_per_core cycles long
	a_req_window: assert property (
		@(posedge clk) disable iff (core_reset)
		$rose(req == 2'd1) |-> (req == 2'd1) [*samples_per_core] ##1 (req == 2'd0)
	);

endmodule

// File: rtl/output_select.sv
module output_select (
	input multicore_pkg::core_out_vec_t core_outs,
	output multicore_pkg::core_out_t io_out
);

	import multicore_pkg::*;

	// ########################################################################
	// Priority select, lowest index wins
	// ########################################################################

	// Scan from the top down so the lowest valid core overwrites the rest
	always_comb begin
		io_out.data = '0;
		io_out.en = en_idle;
		for (int i = num_cores - 1; i >= 0; i--) begin
			if (core_outs[i].en == en_valid)
				io_out = core_outs[i];   // Done cores never match
		end
	end

endmodule

// File: rtl/multicore.sv
module multicore (
	input logic clk,
	input logic reset,
	input multicore_pkg::sample_t io_in,
	output multicore_pkg::core_out_t io_out,
	output multicore_pkg::req_vec_t req
);

	import multicore_pkg::*;

	logic start;
	logic expire;
	logic [num_cores-1:0] core_reset;
	core_out_vec_t core_outs;

	// ########################################################################
	// Staggered release
	// ########################################################################

	dwell_timer timer0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.expire(expire)
	);

	release_fsm seq0 (
		.clk(clk),
		.reset(reset),
		.expire(expire),
		.start(start),
		.core_reset(core_reset)
	);

	// ########################################################################
	// Cores and output selection
	// ########################################################################

	for (genvar i = 0; i < num_cores; i++) begin : g_core
		sample_core core (
			.clk(clk),
			.core_reset(core_reset[i]),
			.io_in(io_in),   // Shared input bus
			.req(req[i]),
			.core_out(core_outs[i])
		);
	end

	output_select sel0 (
		.core_outs(core_outs),
		.io_out(io_out)
	);

endmodule

// File: sim/multicore_tb.sv
module multicore_tb;

	import multicore_pkg::*;

	localparam int half_period = 4;
	localparam int reset_cycles = 16;
	localparam int words_per_core = samples_per_core + 1;   // Samples, then the sum
	localparam int num_words = num_cores * words_per_core;
	localparam int tail_cycles = dwell_cycles;
	localparam int cycle_limit = reset_cycles + num_cores * dwell_cycles + 20;

	// Driven on the shared bus outside any request window
	localparam sample_t idle_in = 32'h5a5a_5a5a;

	logic clk;
	logic reset;
	sample_t io_in;
	core_out_t io_out;
	req_vec_t req;

	sample_t cases [num_words];

	int cycles;
	int n;   // Cycles since reset release
	int next_core;
	int run_core;
	int req_run;
	int valid_count;
	bit valid_due;
	int first_req [num_cores];

	multicore dut0 (
		.clk(clk),
		.reset(reset),
		.io_in(io_in),
		.io_out(io_out),
		.req(req)
	);

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Run limit
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("test failed");
		$fatal(1, "Simulation stopped at the cycle limit");
	end

	// ########################################################################
	// Helpers
	// ########################################################################

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at time %0t: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("test failed");
			$fatal(1, "Mismatch");
		end
	endtask

	function automatic sample_t sum_of_samples(input int core);
		sample_t acc;
		acc = '0;
		for (int i = 0; i < samples_per_core; i++)
			acc = acc + cases[core * words_per_core + i];   // Wraps like the core
		return acc;
	endfunction

	task automatic check_quiet();
		for (int k = 0; k < num_cores; k++)
			check_equal(32'(req[k]), 0, $sformatf("req of core %0d during reset", k));
		check_equal(32'(io_out.en), 32'(en_idle), "output enable during reset");
	endtask

	// Samples the outputs, then drives io_in for the next rising edge
	task automatic observe_cycle();
		int active;
		int nreq;
		active = -1;
		nreq = 0;
		n++;
		for (int k = 0; k < num_cores; k++) begin
			if (req[k] == 2'd1) begin
				nreq++;
				active = k;
			end else begin
				check_equal(32'(req[k]), 0, $sformatf("req code of core %0d", k));
			end
		end
		check_equal(32'(nreq > 1), 0, "more than one core requesting");
		if (n == 1)
			check_equal(active, -1, "request on the first cycle after reset");

		valid_due = 1'b0;
		if (active >= 0) begin
			if (req_run == 0) begin
				check_equal(active, next_core, "core requesting out of order");
				if (active > 0)
					check_equal(n - first_req[active - 1], dwell_cycles,
						$sformatf("release spacing before core %0d", active));
				first_req[active] = n;
				run_core = active;
			end else begin
				check_equal(active, run_core, "request moved to another core");
			end
			req_run++;
			check_equal(32'(req_run > samples_per_core), 0, "request window too long");
			io_in = cases[run_core * words_per_core + req_run - 1];
		end else begin
			if (req_run != 0) begin
				check_equal(req_run, samples_per_core, "request window length");
				valid_due = 1'b1;   // Result is due in this very cycle
				next_core++;
				req_run = 0;
			end
			io_in = idle_in;
		end

		if (valid_due) begin
			check_equal(32'(io_out.en), 32'(en_valid),
				$sformatf("enable code of core %0d result", run_core));
			check_equal(io_out.data, cases[run_core * words_per_core + samples_per_core],
				$sformatf("sum of core %0d", run_core));
			valid_count++;
		end else begin
			check_equal(32'(io_out.en), 32'(en_idle), "enable code outside a result");
			check_equal(io_out.data, 0, "data outside a result");
		end
	endtask

	// ########################################################################
	// Stimulus
	// ########################################################################

	initial begin
		int tail_left;
		reset = 1'b1;
		io_in = idle_in;
		n = 0;
		next_core = 0;
		run_core = 0;
		req_run = 0;
		valid_count = 0;
		valid_due = 1'b0;
		tail_left = tail_cycles;

		$readmemh("sim/multicore_cases.txt", cases);
		for (int k = 0; k < num_cores; k++)
			check_equal(sum_of_samples(k), cases[k * words_per_core + samples_per_core],
				$sformatf("expected sum of core %0d in the cases file", k));

		for (int i = 0; i < reset_cycles; i++) begin
			@(negedge clk);
			if (i >= 1)
				check_quiet();   // Core state settles one edge behind core_reset
		end
		reset = 1'b0;

		while (tail_left > 0) begin
			@(negedge clk);
			observe_cycle();
			if (valid_count == num_cores)
				tail_left--;
		end

		check_equal(valid_count, num_cores, "number of valid outputs");
		$display("test passed");
		$finish;
	end

endmodule

// File: sim/multicore_cases.txt
// Five hex words per core, in core order: samples_per_core signed samples,
// then the expected 32-bit wrapped sum of those samples

// Core 0, small positive values
00000001
00000002
00000003
00000004
0000000a

// Core 1, wraps past the largest positive value
7fffffff
00000001
00000010
00000005
80000015

// Core 2, mixed signs
ffffffff
fffffffe
00000064
fffffff6
00000057

// Core 3, wraps below the most negative value
80000000
ffffffff
0000abcd
00001000
8000bbcc

// File: build.f
rtl/multicore_pkg.sv
rtl/dwell_timer.sv
rtl/release_fsm.sv
rtl/sample_core.sv
rtl/output_select.sv
rtl/multicore.sv
sim/multicore_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= multicore_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= test passed
JOBS ?= 4
VFLAGS ?= --binary --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation OK"; \
	else \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
